/* rtl/decode_params.svh */
// -------------------------------------------------
// Decode stage parameters
// Data width, register address width and the
// RV32I major opcodes
// -------------------------------------------------
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// Major opcodes, instr[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

`endif

/* rtl/decode_pkg.sv */
// -------------------------------------------------
// Decode package
// Micro-op encodings and the structs that carry
// immediates, operand selects and the decoded uop
// -------------------------------------------------
`include "decode_params.svh"

package decode_pkg;

    // ALU micro-ops
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10
    } alu_op_t;

    // Load/store micro-ops
    typedef enum logic [3:0] {
        LSU_NONE = 4'd0,
        LSU_LB   = 4'd1,
        LSU_LBU  = 4'd2,
        LSU_LH   = 4'd3,
        LSU_LHU  = 4'd4,
        LSU_LW   = 4'd5,
        LSU_SB   = 4'd6,
        LSU_SH   = 4'd7,
        LSU_SW   = 4'd8
    } lsu_op_t;

    // Control flow micro-ops
    typedef enum logic [3:0] {
        CFU_NOP  = 4'd0,
        CFU_BEQ  = 4'd1,
        CFU_BNE  = 4'd2,
        CFU_BLT  = 4'd3,
        CFU_BGE  = 4'd4,
        CFU_BLTU = 4'd5,
        CFU_BGEU = 4'd6,
        CFU_JAL  = 4'd7,
        CFU_J    = 4'd8
    } cfu_op_t;

    // Immediate format picked for operand B
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_kind_t;

    typedef struct packed {
        logic [`XLEN-1:0] i;
        logic [`XLEN-1:0] s;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] u;
        logic [`XLEN-1:0] j;
    } imm_set_t;

    typedef struct packed {
        logic      a_rs1;
        logic      a_pc;
        logic      b_rs2;
        logic      b_imm;
        logic      c_rs2;
        logic      c_imm;
        logic      c_npc;
        imm_kind_t b_kind;   // Only meaningful with b_imm
    } opr_sel_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       opr_a;
        logic [`XLEN-1:0]       opr_b;
        logic [`XLEN-1:0]       opr_c;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_t                alu_op;
        lsu_op_t                lsu_op;
        cfu_op_t                cfu_op;
        logic [31:0]            instr;   // Kept for trace
    } decode_uop_t;

endpackage

/* rtl/imm_extract.sv */
// -------------------------------------------------
// Immediate extraction
// Builds the sign-extended I, S, B, U and J
// immediates of an RV32I instruction word
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module imm_extract
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    output imm_set_t         imms
);

    logic sign;

    assign sign = instr[31];   // All formats sign-extend from bit 31

    // -------------------------------------------------
    // I and S formats
    // -------------------------------------------------
    assign imms.i = {{(`XLEN-12){sign}}, instr[31:20]};

    assign imms.s = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};

    // -------------------------------------------------
    // B format, halfword aligned
    // -------------------------------------------------
    assign imms.b = {
        {(`XLEN-13){sign}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // Upper immediate, low 12 bits zero
    assign imms.u = {{(`XLEN-32){sign}}, instr[31:12], 12'b0};

    // -------------------------------------------------
    // J format, halfword aligned
    // -------------------------------------------------
    assign imms.j = {
        {(`XLEN-21){sign}},
        instr[31],
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

endmodule

/* rtl/instr_classify.sv */
// -------------------------------------------------
// Instruction classifier
// Decodes opcode, funct3 and funct7 into ALU, LSU
// and CFU micro-ops plus operand select flags
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_classify
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    input  imm_set_t         imms,
    output opr_sel_t         sel,
    output alu_op_t          alu_op,
    output lsu_op_t          lsu_op,
    output cfu_op_t          cfu_op,
    output logic             jal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] shift_f7;   // Upper I-imm bits, funct7 of shift-immediates
    logic       known;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign shift_f7 = imms.i[11:5];

    always_comb begin
        alu_op = ALU_NOP;
        lsu_op = LSU_NONE;
        cfu_op = CFU_NOP;
        sel    = '0;
        jal    = 1'b0;
        known  = 1'b1;
        case (opcode)
            `OPC_LUI: begin
                alu_op     = ALU_OR;   // Zero OR U-imm
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_U;
            end
            `OPC_AUIPC: begin
                alu_op     = ALU_ADD;
                sel.a_pc   = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_U;
            end
            `OPC_JAL: begin
                cfu_op     = CFU_JAL;
                jal        = 1'b1;
                sel.a_pc   = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_J;
                sel.c_npc  = 1'b1;   // Link address
            end
            `OPC_JALR: begin
                // Target depends on rs1, resolved in execute
                cfu_op     = CFU_JAL;
                known      = (funct3 == 3'b000);
                sel.a_rs1  = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_I;
                sel.c_npc  = 1'b1;
            end
            `OPC_BRANCH: begin
                alu_op    = ALU_SUB;
                sel.a_rs1 = 1'b1;
                sel.b_rs2 = 1'b1;
                sel.c_imm = 1'b1;   // Branch offset
                case (funct3)
                    3'b000:  cfu_op = CFU_BEQ;
                    3'b001:  cfu_op = CFU_BNE;
                    3'b100:  cfu_op = CFU_BLT;
                    3'b101:  cfu_op = CFU_BGE;
                    3'b110:  cfu_op = CFU_BLTU;
                    3'b111:  cfu_op = CFU_BGEU;
                    default: known  = 1'b0;
                endcase
            end
            `OPC_LOAD: begin
                alu_op     = ALU_ADD;   // Address calculation
                sel.a_rs1  = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_I;
                case (funct3)
                    3'b000:  lsu_op = LSU_LB;
                    3'b001:  lsu_op = LSU_LH;
                    3'b010:  lsu_op = LSU_LW;
                    3'b100:  lsu_op = LSU_LBU;
                    3'b101:  lsu_op = LSU_LHU;
                    default: known  = 1'b0;
                endcase
            end
            `OPC_STORE: begin
                alu_op     = ALU_ADD;
                sel.a_rs1  = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_S;
                sel.c_rs2  = 1'b1;   // Store data
                case (funct3)
                    3'b000:  lsu_op = LSU_SB;
                    3'b001:  lsu_op = LSU_SH;
                    3'b010:  lsu_op = LSU_SW;
                    default: known  = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                sel.a_rs1  = 1'b1;
                sel.b_imm  = 1'b1;
                sel.b_kind = IMM_I;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b001: begin
                        if (shift_f7 == 7'b0000000) alu_op = ALU_SLL;
                        else                        known  = 1'b0;
                    end
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: begin
                        if (shift_f7 == 7'b0000000)      alu_op = ALU_SRL;
                        else if (shift_f7 == 7'b0100000) alu_op = ALU_SRA;
                        else                             known  = 1'b0;
                    end
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                endcase
            end
            `OPC_OP: begin
                sel.a_rs1 = 1'b1;
                sel.b_rs2 = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: alu_op = ALU_ADD;
                        3'b001: alu_op = ALU_SLL;
                        3'b010: alu_op = ALU_SLT;
                        3'b011: alu_op = ALU_SLTU;
                        3'b100: alu_op = ALU_XOR;
                        3'b101: alu_op = ALU_SRL;
                        3'b110: alu_op = ALU_OR;
                        3'b111: alu_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op = ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    alu_op = ALU_SRA;
                end else begin
                    known = 1'b0;
                end
            end
            default: known = 1'b0;   // System, fence and reserved
        endcase

        // Unknown instructions carry no work and no operands
        if (!known) begin
            alu_op = ALU_NOP;
            lsu_op = LSU_NONE;
            cfu_op = CFU_NOP;
            sel    = '0;
            jal    = 1'b0;
        end
    end

endmodule

/* rtl/operand_gather.sv */
// -------------------------------------------------
// Operand gather
// AND-OR selection of operands A, B and C from
// register data, PC, next PC and the immediates
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module operand_gather
    import decode_pkg::*;
(
    input  opr_sel_t         sel,
    input  imm_set_t         imms,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] npc,
    output logic [`XLEN-1:0] opr_a,
    output logic [`XLEN-1:0] opr_b,
    output logic [`XLEN-1:0] opr_c
);

    logic [`XLEN-1:0] b_imm;

    // Immediate for operand B by format
    assign b_imm =
        ({`XLEN{sel.b_kind == IMM_I}} & imms.i) |
        ({`XLEN{sel.b_kind == IMM_S}} & imms.s) |
        ({`XLEN{sel.b_kind == IMM_B}} & imms.b) |
        ({`XLEN{sel.b_kind == IMM_U}} & imms.u) |
        ({`XLEN{sel.b_kind == IMM_J}} & imms.j);

    // -------------------------------------------------
    // Operands, zero when nothing is selected
    // -------------------------------------------------
    assign opr_a =
        ({`XLEN{sel.a_rs1}} & rs1_data) |
        ({`XLEN{sel.a_pc }} & pc      );

    assign opr_b =
        ({`XLEN{sel.b_rs2}} & rs2_data) |
        ({`XLEN{sel.b_imm}} & b_imm   );

    assign opr_c =
        ({`XLEN{sel.c_rs2}} & rs2_data) |
        ({`XLEN{sel.c_imm}} & imms.b  ) |   // Branch offset
        ({`XLEN{sel.c_npc}} & npc     );

endmodule

/* rtl/decode_issue.sv */
// -------------------------------------------------
// Decode issue
// JAL redirect, instruction acceptance and the
// one-deep decode-to-execute register
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_issue
    import decode_pkg::*;
(
    input  logic             g_clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             s1_valid,
    input  logic [`XLEN-1:0] s1_instr,
    input  logic [`XLEN-1:0] s1_pc,
    input  logic             jal,
    input  logic [`XLEN-1:0] imm_j,
    input  logic [`XLEN-1:0] opr_a,
    input  logic [`XLEN-1:0] opr_b,
    input  logic [`XLEN-1:0] opr_c,
    input  alu_op_t          alu_op,
    input  lsu_op_t          lsu_op,
    input  cfu_op_t          cfu_op,
    input  logic             cf_ack,
    input  logic             s2_ready,
    output logic             s1_eat,
    output logic             cf_valid,
    output logic [`XLEN-1:0] cf_target,
    output logic             s2_valid,
    output decode_uop_t      s2_uop
);

    logic        cf_wait;
    logic        reg_free;
    decode_uop_t n_uop;

    // -------------------------------------------------
    // Redirect for JAL, target known at decode
    // -------------------------------------------------
    assign cf_valid  = s1_valid && jal;
    assign cf_target = s1_pc + imm_j;
    assign cf_wait   = cf_valid && !cf_ack;   // Hold the JAL until fetch acks

    assign reg_free = !s2_valid || s2_ready;
    assign s1_eat   = s1_valid && !cf_wait && !flush && reg_free;

    always_comb begin
        n_uop        = '0;
        n_uop.pc     = s1_pc;
        n_uop.opr_a  = opr_a;
        n_uop.opr_b  = opr_b;
        n_uop.opr_c  = opr_c;
        n_uop.rd     = s1_instr[11:7];
        n_uop.alu_op = alu_op;
        n_uop.lsu_op = lsu_op;
        n_uop.cfu_op = cfu_op;
        n_uop.instr  = s1_instr;
    end

    // -------------------------------------------------
    // Decode to execute register
    // -------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            s2_valid <= 1'b0;
            s2_uop   <= '0;
        end else if (s1_eat) begin
            s2_valid <= 1'b1;
            s2_uop   <= n_uop;
        end else if (s2_ready) begin
            s2_valid <= 1'b0;   // Drained, nothing new
        end
    end

    // Execute must see a steady uop while it stalls
    a_uop_stable : assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (s2_valid && !s2_ready && !flush) |=> $stable(s2_uop)
    );

    // Nothing enters the execute register while a redirect waits for its ack
    a_no_eat_cf_wait : assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (cf_valid && !cf_ack && (!s2_valid || s2_ready)) |=> !s2_valid
    );

endmodule

/* rtl/core_decode.sv */
// -------------------------------------------------
// Decode and operand gather stage, RV32I
// Top level joining immediates, classifier,
// operand gather and issue register
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module core_decode
    import decode_pkg::*;
(
    input  logic                   g_clk,
    input  logic                   rst_n,
    input  logic                   flush,
    // Fetch side
    input  logic                   s1_valid,
    input  logic [`XLEN-1:0]       s1_instr,
    input  logic [`XLEN-1:0]       s1_pc,
    input  logic [`XLEN-1:0]       s1_npc,
    output logic                   s1_eat,
    // Redirect
    output logic                   cf_valid,
    input  logic                   cf_ack,
    output logic [`XLEN-1:0]       cf_target,
    // Register file
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs2_data,
    // Execute
    output logic                   s2_valid,
    input  logic                   s2_ready,
    output decode_uop_t            s2_uop
);

    imm_set_t         imms;
    opr_sel_t         sel;
    alu_op_t          alu_op;
    lsu_op_t          lsu_op;
    cfu_op_t          cfu_op;
    logic             jal;
    logic [`XLEN-1:0] opr_a;
    logic [`XLEN-1:0] opr_b;
    logic [`XLEN-1:0] opr_c;

    // Register addresses straight from the encoding
    assign rs1_addr = s1_instr[19:15];
    assign rs2_addr = s1_instr[24:20];

    imm_extract u_imm_extract (
        .instr (s1_instr),
        .imms  (imms)
    );

    instr_classify u_instr_classify (
        .instr  (s1_instr),
        .imms   (imms),
        .sel    (sel),
        .alu_op (alu_op),
        .lsu_op (lsu_op),
        .cfu_op (cfu_op),
        .jal    (jal)
    );

    operand_gather u_operand_gather (
        .sel      (sel),
        .imms     (imms),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (s1_pc),
        .npc      (s1_npc),
        .opr_a    (opr_a),
        .opr_b    (opr_b),
        .opr_c    (opr_c)
    );

    decode_issue u_decode_issue (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .s1_valid  (s1_valid),
        .s1_instr  (s1_instr),
        .s1_pc     (s1_pc),
        .jal       (jal),
        .imm_j     (imms.j),
        .opr_a     (opr_a),
        .opr_b     (opr_b),
        .opr_c     (opr_c),
        .alu_op    (alu_op),
        .lsu_op    (lsu_op),
        .cfu_op    (cfu_op),
        .cf_ack    (cf_ack),
        .s2_ready  (s2_ready),
        .s1_eat    (s1_eat),
        .cf_valid  (cf_valid),
        .cf_target (cf_target),
        .s2_valid  (s2_valid),
        .s2_uop    (s2_uop)
    );

endmodule

/* test/tb_clock.sv */
// -------------------------------------------------
// Testbench clock and reset
// 10 ns g_clk, rst_n low for the first 2 cycles
// -------------------------------------------------
`timescale 1ns/1ps

module tb_clock (
    output logic g_clk,
    output logic rst_n
);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge g_clk);
        #1 rst_n = 1'b1;   // Released with the other inputs
    end

endmodule

/* test/tb_decode_model.svh */
// -------------------------------------------------
// Reference decode model
// Expected RV32I uop per instruction and the
// random instruction generator
// -------------------------------------------------
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

`include "decode_params.svh"

// Immediates straight from the RV32I encoding tables
function automatic logic [`XLEN-1:0] i_imm(input logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic logic [`XLEN-1:0] s_imm(input logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

function automatic logic [`XLEN-1:0] b_imm(input logic [31:0] ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic logic [`XLEN-1:0] u_imm(input logic [31:0] ins);
    return {ins[31:12], 12'b0};
endfunction

function automatic logic [`XLEN-1:0] j_imm(input logic [31:0] ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

// -------------------------------------------------
// Expected uop, operands computed directly
// -------------------------------------------------
function automatic decode_uop_t expect_uop(
    input logic [31:0]       ins,
    input logic [`XLEN-1:0] pc,
    input logic [`XLEN-1:0] npc,
    input logic [`XLEN-1:0] r1,
    input logic [`XLEN-1:0] r2
);
    decode_uop_t u;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    u  = '0;
    f3 = ins[14:12];
    f7 = ins[31:25];
    ok = 1'b1;
    case (ins[6:0])
        `OPC_LUI: begin
            u.alu_op = ALU_OR;
            u.opr_b  = u_imm(ins);
        end
        `OPC_AUIPC: begin
            u.alu_op = ALU_ADD;
            u.opr_a  = pc;
            u.opr_b  = u_imm(ins);
        end
        `OPC_JAL: begin
            u.cfu_op = CFU_JAL;
            u.opr_a  = pc;
            u.opr_b  = j_imm(ins);
            u.opr_c  = npc;
        end
        `OPC_JALR: begin
            ok       = (f3 == 3'b000);
            u.cfu_op = CFU_JAL;
            u.opr_a  = r1;
            u.opr_b  = i_imm(ins);
            u.opr_c  = npc;
        end
        `OPC_BRANCH: begin
            u.alu_op = ALU_SUB;
            u.opr_a  = r1;
            u.opr_b  = r2;
            u.opr_c  = b_imm(ins);
            case (f3)
                3'b000:  u.cfu_op = CFU_BEQ;
                3'b001:  u.cfu_op = CFU_BNE;
                3'b100:  u.cfu_op = CFU_BLT;
                3'b101:  u.cfu_op = CFU_BGE;
                3'b110:  u.cfu_op = CFU_BLTU;
                3'b111:  u.cfu_op = CFU_BGEU;
                default: ok = 1'b0;
            endcase
        end
        `OPC_LOAD: begin
            u.alu_op = ALU_ADD;
            u.opr_a  = r1;
            u.opr_b  = i_imm(ins);
            case (f3)
                3'b000:  u.lsu_op = LSU_LB;
                3'b001:  u.lsu_op = LSU_LH;
                3'b010:  u.lsu_op = LSU_LW;
                3'b100:  u.lsu_op = LSU_LBU;
                3'b101:  u.lsu_op = LSU_LHU;
                default: ok = 1'b0;
            endcase
        end
        `OPC_STORE: begin
            u.alu_op = ALU_ADD;
            u.opr_a  = r1;
            u.opr_b  = s_imm(ins);
            u.opr_c  = r2;
            case (f3)
                3'b000:  u.lsu_op = LSU_SB;
                3'b001:  u.lsu_op = LSU_SH;
                3'b010:  u.lsu_op = LSU_SW;
                default: ok = 1'b0;
            endcase
        end
        `OPC_OP_IMM: begin
            u.opr_a = r1;
            u.opr_b = i_imm(ins);
            case (f3)
                3'b000:  u.alu_op = ALU_ADD;
                3'b010:  u.alu_op = ALU_SLT;
                3'b011:  u.alu_op = ALU_SLTU;
                3'b100:  u.alu_op = ALU_XOR;
                3'b110:  u.alu_op = ALU_OR;
                3'b111:  u.alu_op = ALU_AND;
                3'b001:  if (f7 == 7'h00) u.alu_op = ALU_SLL; else ok = 1'b0;
                default: begin   // Right shifts
                    if (f7 == 7'h00)      u.alu_op = ALU_SRL;
                    else if (f7 == 7'h20) u.alu_op = ALU_SRA;
                    else                  ok = 1'b0;
                end
            endcase
        end
        `OPC_OP: begin
            u.opr_a = r1;
            u.opr_b = r2;
            case ({f7, f3})
                {7'h00, 3'b000}: u.alu_op = ALU_ADD;
                {7'h20, 3'b000}: u.alu_op = ALU_SUB;
                {7'h00, 3'b001}: u.alu_op = ALU_SLL;
                {7'h00, 3'b010}: u.alu_op = ALU_SLT;
                {7'h00, 3'b011}: u.alu_op = ALU_SLTU;
                {7'h00, 3'b100}: u.alu_op = ALU_XOR;
                {7'h00, 3'b101}: u.alu_op = ALU_SRL;
                {7'h20, 3'b101}: u.alu_op = ALU_SRA;
                {7'h00, 3'b110}: u.alu_op = ALU_OR;
                {7'h00, 3'b111}: u.alu_op = ALU_AND;
                default:         ok = 1'b0;
            endcase
        end
        default: ok = 1'b0;
    endcase
    if (!ok) u = '0;   // No ops, no operands
    u.pc    = pc;
    u.rd    = ins[11:7];
    u.instr = ins;
    return u;
endfunction

// -------------------------------------------------
// Random instruction, mostly kept classes
// -------------------------------------------------
function automatic logic [31:0] gen_instr();
    logic [31:0] ins;
    logic [31:0] pick;
    logic [31:0] f;
    ins  = rand_bits(32);
    pick = rand_bits(4);
    f    = rand_bits(3);
    case (pick[3:0])
        4'd0:           ins[6:0] = `OPC_LUI;
        4'd1:           ins[6:0] = `OPC_AUIPC;
        4'd2:           ins[6:0] = `OPC_JAL;
        4'd3:           ins[6:0] = `OPC_JALR;
        4'd4:           ins[6:0] = `OPC_BRANCH;
        4'd5:           ins[6:0] = `OPC_LOAD;
        4'd6:           ins[6:0] = `OPC_STORE;
        4'd7, 4'd9:     ins[6:0] = `OPC_OP_IMM;
        4'd8, 4'd10:    ins[6:0] = `OPC_OP;
        4'd11:          ins[6:0] = 7'b1110011;   // System
        4'd12:          ins[6:0] = 7'b0001111;   // Fence
        default:        ins[6:0] = ins[6:0];     // Random, mostly reserved
    endcase
    // Legal funct7 most of the time
    if (ins[6:0] == `OPC_OP || (ins[6:0] == `OPC_OP_IMM && ins[13:12] == 2'b01)) begin
        if (f[2:0] < 3'd3)      ins[31:25] = 7'h00;
        else if (f[2:0] < 3'd6) ins[31:25] = 7'h20;
    end
    if (ins[6:0] == `OPC_JALR && f[2:0] != 3'd7) ins[14:12] = 3'b000;
    return ins;
endfunction

`endif

/* test/tb_core_decode.sv */
// -------------------------------------------------
// Decode stage testbench
// Random RV32I stream with random handshakes,
// checked against the reference decode model
// -------------------------------------------------
`timescale 1ns/1ps
`include "decode_params.svh"

module tb_core_decode
    import decode_pkg::*;
;

    localparam int NUM_INSTR  = 2000;
    localparam int MAX_CYCLES = NUM_INSTR * 5;   // Instructions plus 4x margin

    logic                   g_clk;
    logic                   rst_n;
    logic                   flush;
    logic                   s1_valid;
    logic [`XLEN-1:0]       s1_instr;
    logic [`XLEN-1:0]       s1_pc;
    logic [`XLEN-1:0]       s1_npc;
    logic                   s1_eat;
    logic                   cf_valid;
    logic                   cf_ack;
    logic [`XLEN-1:0]       cf_target;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   s2_valid;
    logic                   s2_ready;
    decode_uop_t            s2_uop;

    logic [31:0]      lfsr_state = 32'h2025_1d00;
    logic [`XLEN-1:0] regs [32];
    decode_uop_t      exp_q [$];   // Accepted, not yet at execute
    decode_uop_t      held_uop;
    logic             held_chk = 1'b0;
    int               errors = 0;
    int               done_cnt = 0;
    int               cycles = 0;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    `include "tb_decode_model.svh"

    tb_clock u_clock (
        .g_clk (g_clk),
        .rst_n (rst_n)
    );

    core_decode DUT (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .s1_valid  (s1_valid),
        .s1_instr  (s1_instr),
        .s1_pc     (s1_pc),
        .s1_npc    (s1_npc),
        .s1_eat    (s1_eat),
        .cf_valid  (cf_valid),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .rs1_addr  (rs1_addr),
        .rs1_data  (rs1_data),
        .rs2_addr  (rs2_addr),
        .rs2_data  (rs2_data),
        .s2_valid  (s2_valid),
        .s2_ready  (s2_ready),
        .s2_uop    (s2_uop)
    );

    // Register file answers in the same cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // -------------------------------------------------
    // Compare tasks
    // -------------------------------------------------
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_uop(input string name, input decode_uop_t got, input decode_uop_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic verify_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    // Mid-cycle view of one clock, updates the model for the coming edge
    task automatic observe_cycle();
        logic        exp_valid;
        logic        exp_cf;
        logic        exp_eat;
        decode_uop_t head;
        exp_valid = (exp_q.size() != 0);
        verify_bit("s2_valid", s2_valid, exp_valid);
        check_word("rs1_addr", {{(`XLEN-`REG_ADDR_W){1'b0}}, rs1_addr},
                   {{(`XLEN-`REG_ADDR_W){1'b0}}, s1_instr[19:15]});
        check_word("rs2_addr", {{(`XLEN-`REG_ADDR_W){1'b0}}, rs2_addr},
                   {{(`XLEN-`REG_ADDR_W){1'b0}}, s1_instr[24:20]});
        exp_cf = s1_valid && (s1_instr[6:0] == `OPC_JAL);
        verify_bit("cf_valid", cf_valid, exp_cf);
        if (exp_cf) check_word("cf_target", cf_target, s1_pc + j_imm(s1_instr));
        exp_eat = s1_valid && !(exp_cf && !cf_ack) && !flush && (!exp_valid || s2_ready);
        verify_bit("s1_eat", s1_eat, exp_eat);
        if (held_chk) compare_uop("s2_uop under stall", s2_uop, held_uop);
        held_chk = s2_valid && !s2_ready && !flush;
        held_uop = s2_uop;
        if (s2_valid && s2_ready) begin
            head = exp_q.pop_front();
            compare_uop("s2_uop", s2_uop, head);
            done_cnt++;
        end else if (flush && exp_valid) begin
            exp_q.delete(0);   // Flushed before execute took it
        end
        if (s1_eat) begin
            exp_q.push_back(expect_uop(s1_instr, s1_pc, s1_npc,
                                       regs[s1_instr[19:15]], regs[s1_instr[24:20]]));
        end
    endtask

    // Fetch holds an offered instruction until it is eaten
    task automatic drive_inputs(input logic took);
        logic [31:0] r;
        logic [31:0] addr;
        r        = rand_bits(12);
        s2_ready = (r[1:0] != 2'b00);
        cf_ack   = r[2];
        flush    = (r[8:3] == 6'd0);   // Rare
        if (took || !s1_valid) begin
            addr     = rand_bits(30);
            s1_valid = (r[11:9] != 3'd0);
            s1_instr = gen_instr();
            s1_pc    = {addr[29:0], 2'b00};
            s1_npc   = s1_pc + 32'd4;
        end
    endtask

    // -------------------------------------------------
    // Main sequence
    // -------------------------------------------------
    initial begin
        logic took;
        flush    = 1'b0;
        s1_valid = 1'b0;
        s1_instr = '0;
        s1_pc    = '0;
        s1_npc   = '0;
        cf_ack   = 1'b0;
        s2_ready = 1'b0;
        for (int i = 0; i < 32; i++) regs[i] = rand_bits(32);
        @(posedge rst_n);
        while (done_cnt < NUM_INSTR) begin
            @(negedge g_clk);
            took = s1_eat;
            observe_cycle();
            @(posedge g_clk);
            #1;
            drive_inputs(took);
        end
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("ERROR: timeout, %0d of %0d uops reached execute in %0d cycles",
                     done_cnt, NUM_INSTR, cycles);
            abort_run();
        end
    end

endmodule

/* core_decode.f */
+incdir+rtl
+incdir+test
rtl/decode_pkg.sv
rtl/imm_extract.sv
rtl/instr_classify.sv
rtl/operand_gather.sv
rtl/decode_issue.sv
rtl/core_decode.sv
test/tb_clock.sv
test/tb_core_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core_decode -f core_decode.f -o tb_core_decode \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_core_decode > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
